//--- rover_ctrl.f
rtl/rover_pkg.sv
rtl/ir_nec_decoder.sv
rtl/drive_mode_fsm.sv
rtl/motor_pwm.sv
rtl/apb_drive_regs.sv
rtl/rover_ctrl.sv
testbench/tb_rover_ctrl.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_rover_ctrl
FILELIST = rover_ctrl.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_rover_ctrl.sv
`timescale 1ns/1ns

module tb_rover_ctrl
    import rover_pkg::*;
();

    typedef enum logic [2:0] {
        ACT_IR,
        ACT_IR_BAD,
        ACT_CAM,
        ACT_WR,
        ACT_RD
    } act_e;

    typedef struct {
        act_e       act;
        logic [3:0] addr;
        logic [7:0] data;            // Key, camera word, write data or expected read data
        logic       exp_err;
        logic [7:0] exp_status;
        logic [7:0] exp_high_l;
        logic [7:0] exp_high_r;
        logic       exp_fwd_l;
        logic       exp_fwd_r;
    } step_t;

    // A frame is at most about 160 IR units, so six frames plus the 256-cycle
    // windows of every step stay far below this limit
    localparam int TIMEOUT_CYCLES  = 400_000;
    localparam int SETTLE_CYCLES   = 8;
    localparam int KEY_WAIT_CYCLES = 12;

    localparam logic [7:0] SLOW_D  = 8'd64;
    localparam logic [7:0] MED_D   = 8'd128;
    localparam logic [7:0] FAST_D  = 8'd192;
    localparam logic [7:0] TURN    = 8'd96;
    localparam logic [7:0] NEW_MED = 8'h50;

    logic        clk_50;
    logic        rst_n;
    logic        ir_in;
    cam_status_t cam_status;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    motor_cmd_t  motor;

    step_t steps[$];
    int    seed        = 32942;
    int    cycle_cnt   = 0;
    int    error_count = 0;
    int    cur_step    = 0;

    rover_ctrl rover_ctrl_i (
        .clk_50     (clk_50),
        .rst_n      (rst_n),
        .ir_in      (ir_in),
        .cam_status (cam_status),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .motor      (motor)
    );

    always #50 clk_50 = ~clk_50;

    always @(posedge clk_50) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_cnt);
            $display("tests failed");
            $fatal(1, "Simulation timed out");
        end
    end

    // ==========================================================
    // Helpers
    // ==========================================================

    task automatic check(input string name, input int actual, input int expected);
        if (actual != expected) begin
            error_count++;
            $display("Error: step %0d %s is 0x%0h, expected 0x%0h",
                     cur_step, name, actual, expected);
            $display("tests failed");
            $fatal(1, "Check failed");
        end
    endtask

    task automatic hold_ir(input logic level, input int units);
        ir_in = level;
        repeat (units * IR_TICK_DIV) @(posedge clk_50);
        #10;
    endtask

    // Sends an NEC frame with every byte LSB first and waits for the decoded key
    task automatic send_ir(input logic [7:0] key, input logic corrupt);
        logic [7:0]  addr;
        logic [31:0] frame;
        logic        seen;
        addr  = 8'($random(seed));
        frame = {~key ^ {7'b0, corrupt}, key, ~addr, addr};
        hold_ir(1'b0, IR_LEAD_MIN + 4);      // Lead mark of 16 units
        hold_ir(1'b1, 8);
        for (int i = 0; i < IR_FRAME_BITS; i++) begin
            hold_ir(1'b0, 1);
            hold_ir(1'b1, frame[i] ? IR_BIT_ONE + 1 : 1);
        end
        hold_ir(1'b0, 1);                    // Stop mark
        ir_in = 1'b1;
        seen  = 1'b0;
        for (int c = 0; c < KEY_WAIT_CYCLES && !seen; c++) begin
            @(posedge clk_50);
            #10;
            seen = rover_ctrl_i.key_valid;
        end
        check("key_valid", int'(seen), int'(!corrupt));
        if (seen) begin
            check("key_code", int'(rover_ctrl_i.key_code), int'(key));
        end
    endtask

    task automatic apb_access(input logic write, input logic [3:0] addr,
                              input logic [7:0] wdata,
                              output logic [7:0] rdata, output logic err);
        apb_req.psel    = 1'b1;              // Setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk_50);
        #10;
        apb_req.penable = 1'b1;
        #40;
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check("pready", int'(apb_rsp.pready), 1);
        @(posedge clk_50);
        #10;
        apb_req = '0;
    endtask

    task automatic measure_pwm(output int high_l, output int high_r);
        high_l = 0;
        high_r = 0;
        repeat (1 << PWM_BITS) begin
            if (motor.duty_left != '0) high_l++;
            if (motor.duty_right != '0) high_r++;
            @(posedge clk_50);
            #10;
        end
    endtask

    function automatic logic [7:0] cam_word(input logic seen, input cam_dir_e dir,
                                            input logic [1:0] speed);
        return {2'b00, seen, dir, speed};
    endfunction

    function automatic void add_step(input act_e act, input logic [3:0] addr,
                                     input logic [7:0] data, input logic exp_err,
                                     input logic [7:0] exp_status,
                                     input logic [7:0] high_l, input logic [7:0] high_r,
                                     input logic fwd_l, input logic fwd_r);
        step_t st;
        st = '{act, addr, data, exp_err, exp_status, high_l, high_r, fwd_l, fwd_r};
        steps.push_back(st);
    endfunction

    // ==========================================================
    // Stimulus table and run loop
    // ==========================================================

    initial begin
        step_t      st;
        logic [7:0] rdata;
        logic       err;
        int         high_l;
        int         high_r;
        clk_50     = 1'b0;
        rst_n      = 1'b0;
        ir_in      = 1'b1;                   // Receiver line idles high
        cam_status = '0;
        apb_req    = '0;

        // Status 0x0c is IDLE with PAUSE, 0x01 CAM with SEARCH, 0x05 CAM with FOLLOW
        add_step(ACT_RD,     REG_DUTY_SLOW, SLOW_D, 1'b0, 8'h0c, 8'd0, 8'd0, 1'b0, 1'b0);
        add_step(ACT_IR_BAD, 4'd0, KEY_CAM, 1'b0, 8'h0c, 8'd0, 8'd0, 1'b0, 1'b0);
        add_step(ACT_IR,     4'd0, KEY_CAM, 1'b0, 8'h01, TURN, TURN, 1'b1, 1'b0);
        add_step(ACT_CAM, 4'd0, cam_word(1'b1, DIR_AHEAD, 2'd0),
                 1'b0, 8'h05, SLOW_D, SLOW_D, 1'b1, 1'b1);
        add_step(ACT_CAM, 4'd0, cam_word(1'b1, DIR_AHEAD, 2'd1),
                 1'b0, 8'h05, MED_D, MED_D, 1'b1, 1'b1);
        add_step(ACT_CAM, 4'd0, cam_word(1'b1, DIR_AHEAD, 2'd2),
                 1'b0, 8'h05, FAST_D, FAST_D, 1'b1, 1'b1);
        add_step(ACT_CAM, 4'd0, cam_word(1'b1, DIR_AHEAD, 2'd3),
                 1'b0, 8'h05, 8'd0, 8'd0, 1'b0, 1'b0);
        add_step(ACT_CAM, 4'd0, cam_word(1'b1, DIR_LEFT, 2'd0),
                 1'b0, 8'h05, TURN, TURN, 1'b0, 1'b1);
        add_step(ACT_CAM, 4'd0, cam_word(1'b1, DIR_RIGHT, 2'd0),
                 1'b0, 8'h05, TURN, TURN, 1'b1, 1'b0);
        add_step(ACT_CAM, 4'd0, cam_word(1'b0, DIR_NONE, 2'd0),
                 1'b0, 8'h01, TURN, TURN, 1'b1, 1'b0);
        add_step(ACT_CAM, 4'd0, cam_word(1'b1, DIR_AHEAD, 2'd1),
                 1'b0, 8'h05, MED_D, MED_D, 1'b1, 1'b1);
        // The error cases among the register accesses must leave every register as it was
        add_step(ACT_WR, REG_DUTY_MED,  NEW_MED, 1'b0, 8'h05, NEW_MED, NEW_MED, 1'b1, 1'b1);
        add_step(ACT_RD, REG_DUTY_MED,  NEW_MED, 1'b0, 8'h05, NEW_MED, NEW_MED, 1'b1, 1'b1);
        add_step(ACT_WR, 4'd5,          8'haa,   1'b1, 8'h05, NEW_MED, NEW_MED, 1'b1, 1'b1);
        add_step(ACT_RD, 4'd5,          8'h00,   1'b1, 8'h05, NEW_MED, NEW_MED, 1'b1, 1'b1);
        add_step(ACT_WR, REG_STATUS,    8'h00,   1'b1, 8'h05, NEW_MED, NEW_MED, 1'b1, 1'b1);
        add_step(ACT_RD, REG_DUTY_SLOW, SLOW_D,  1'b0, 8'h05, NEW_MED, NEW_MED, 1'b1, 1'b1);
        add_step(ACT_RD, REG_DUTY_FAST, FAST_D,  1'b0, 8'h05, NEW_MED, NEW_MED, 1'b1, 1'b1);
        add_step(ACT_RD, REG_DUTY_TURN, TURN,    1'b0, 8'h05, NEW_MED, NEW_MED, 1'b1, 1'b1);
        add_step(ACT_IR_BAD, 4'd0, KEY_IR,   1'b0, 8'h05, NEW_MED, NEW_MED, 1'b1, 1'b1);
        add_step(ACT_IR,     4'd0, KEY_IR,   1'b0, 8'h0e, 8'd0, 8'd0, 1'b0, 1'b0);
        add_step(ACT_IR,     4'd0, KEY_CAM,  1'b0, 8'h05, NEW_MED, NEW_MED, 1'b1, 1'b1);
        add_step(ACT_IR,     4'd0, KEY_IDLE, 1'b0, 8'h0c, 8'd0, 8'd0, 1'b0, 1'b0);

        repeat (3) @(posedge clk_50);
        #10;
        rst_n = 1'b1;

        foreach (steps[i]) begin
            cur_step = i;
            st       = steps[i];
            case (st.act)
                ACT_IR:     send_ir(st.data, 1'b0);
                ACT_IR_BAD: send_ir(st.data, 1'b1);
                ACT_CAM:    cam_status = cam_status_t'(st.data[5:0]);
                default: begin
                    apb_access(st.act == ACT_WR, st.addr, st.data, rdata, err);
                    check("pslverr", int'(err), int'(st.exp_err));
                    if (st.act == ACT_RD && !st.exp_err) begin
                        check("prdata", int'(rdata), int'(st.data));
                    end
                end
            endcase
            repeat (SETTLE_CYCLES) @(posedge clk_50);
            #10;
            apb_access(1'b0, REG_STATUS, 8'h00, rdata, err);
            check("status pslverr", int'(err), 0);
            check("status", int'(rdata), int'(st.exp_status));
            measure_pwm(high_l, high_r);
            check("duty_left high count", high_l, int'(st.exp_high_l));
            check("duty_right high count", high_r, int'(st.exp_high_r));
            check("fwd_left", int'(motor.fwd_left), int'(st.exp_fwd_l));
            check("fwd_right", int'(motor.fwd_right), int'(st.exp_fwd_r));
        end

        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- rtl/rover_ctrl.sv
`timescale 1ns/1ns

module rover_ctrl
    import rover_pkg::*;
(
    input  logic        clk_50,
    input  logic        rst_n,
    input  logic        ir_in,
    input  cam_status_t cam_status,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    output motor_cmd_t  motor
);

    logic       key_valid;
    logic [7:0] key_code;
    mode_e      mode;
    cam_state_e cam_state;
    drive_e     drive_action;
    logic       mode_change;            // Restarts the PWM period
    logic [7:0] duty_slow;
    logic [7:0] duty_med;
    logic [7:0] duty_fast;
    logic [7:0] duty_turn;

    ir_nec_decoder ir_dec_i (
        .clk_50    (clk_50),
        .rst_n     (rst_n),
        .ir_in     (ir_in),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    drive_mode_fsm mode_fsm_i (
        .clk_50       (clk_50),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .key_code     (key_code),
        .cam_status   (cam_status),
        .mode         (mode),
        .cam_state    (cam_state),
        .drive_action (drive_action),
        .mode_change  (mode_change)
    );

    apb_drive_regs regs_i (
        .clk_50    (clk_50),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .mode      (mode),
        .cam_state (cam_state),
        .duty_slow (duty_slow),
        .duty_med  (duty_med),
        .duty_fast (duty_fast),
        .duty_turn (duty_turn)
    );

    motor_pwm pwm_i (
        .clk_50       (clk_50),
        .rst_n        (rst_n),
        .drive_action (drive_action),
        .mode_change  (mode_change),
        .duty_slow    (duty_slow),
        .duty_med     (duty_med),
        .duty_fast    (duty_fast),
        .duty_turn    (duty_turn),
        .motor        (motor)
    );

endmodule

//--- rtl/apb_drive_regs.sv
`timescale 1ns/1ns

module apb_drive_regs
    import rover_pkg::*;
(
    input  logic       clk_50,
    input  logic       rst_n,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    input  mode_e      mode,
    input  cam_state_e cam_state,
    output logic [7:0] duty_slow,
    output logic [7:0] duty_med,
    output logic [7:0] duty_fast,
    output logic [7:0] duty_turn
);

    logic access;
    logic addr_err;
    logic wr_en;

    // ==========================================================
    // Access decode
    // ==========================================================

    assign access   = apb_req.psel && apb_req.penable;  // No wait states
    assign addr_err = (apb_req.paddr > REG_STATUS) ||
                      (apb_req.pwrite && apb_req.paddr == REG_STATUS);
    assign wr_en    = access && apb_req.pwrite && !addr_err;

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            duty_slow <= DUTY_SLOW_RST;
            duty_med  <= DUTY_MED_RST;
            duty_fast <= DUTY_FAST_RST;
            duty_turn <= DUTY_TURN_RST;
        end else if (wr_en) begin
            case (apb_req.paddr)
                REG_DUTY_SLOW: duty_slow <= apb_req.pwdata;
                REG_DUTY_MED:  duty_med  <= apb_req.pwdata;
                REG_DUTY_FAST: duty_fast <= apb_req.pwdata;
                REG_DUTY_TURN: duty_turn <= apb_req.pwdata;
                default: ;
            endcase
        end
    end

    // ==========================================================
    // Read response
    // ==========================================================

    always_comb begin
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && addr_err;
        if (access && !apb_req.pwrite) begin
            case (apb_req.paddr)
                REG_DUTY_SLOW: apb_rsp.prdata = duty_slow;
                REG_DUTY_MED:  apb_rsp.prdata = duty_med;
                REG_DUTY_FAST: apb_rsp.prdata = duty_fast;
                REG_DUTY_TURN: apb_rsp.prdata = duty_turn;
                REG_STATUS:    apb_rsp.prdata = {4'b0000, cam_state, mode};
                default:       apb_rsp.prdata = '0;
            endcase
        end
    end

    a_penable_needs_psel: assert property (@(posedge clk_50) disable iff (!rst_n)
        apb_req.penable |-> apb_req.psel);

endmodule

//--- rtl/motor_pwm.sv
`timescale 1ns/1ns

module motor_pwm
    import rover_pkg::*;
(
    input  logic       clk_50,
    input  logic       rst_n,
    input  drive_e     drive_action,
    input  logic       mode_change,
    input  logic [7:0] duty_slow,
    input  logic [7:0] duty_med,
    input  logic [7:0] duty_fast,
    input  logic [7:0] duty_turn,
    output motor_cmd_t motor
);

    logic [PWM_BITS-1:0] pwm_cnt;
    logic [7:0]          sel_duty;
    logic                fwd_left;
    logic                fwd_right;

    // Map the action onto the wheel duty and the per-wheel direction
    always_comb begin
        case (drive_action)
            SLOW:        sel_duty = duty_slow;
            MEDIUM:      sel_duty = duty_med;
            FAST:        sel_duty = duty_fast;
            LEFT, RIGHT: sel_duty = duty_turn;  // Turns differ only in direction
            default:     sel_duty = '0;         // STOP leaves both wheels idle
        endcase
        fwd_left  = (drive_action inside {SLOW, MEDIUM, FAST, RIGHT});
        fwd_right = (drive_action inside {SLOW, MEDIUM, FAST, LEFT});
    end

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            pwm_cnt <= '0;
            motor   <= '0;
        end else begin
            pwm_cnt          <= mode_change ? '0 : pwm_cnt + 1'b1;  // Wraps every 256
            motor.duty_left  <= (pwm_cnt < sel_duty) ? '1 : '0;
            motor.duty_right <= (pwm_cnt < sel_duty) ? '1 : '0;
            motor.fwd_left   <= fwd_left;
            motor.fwd_right  <= fwd_right;
        end
    end

endmodule

//--- rtl/drive_mode_fsm.sv
`timescale 1ns/1ns

module drive_mode_fsm
    import rover_pkg::*;
(
    input  logic        clk_50,
    input  logic        rst_n,
    input  logic        key_valid,
    input  logic [7:0]  key_code,
    input  cam_status_t cam_status,
    output mode_e       mode,
    output cam_state_e  cam_state,
    output drive_e      drive_action,
    output logic        mode_change
);

    mode_e      next_mode;
    cam_state_e next_cam;
    drive_e     next_drive;

    // ==========================================================
    // Next-state logic
    // ==========================================================

    always_comb begin
        next_mode = mode;
        if (key_valid) begin
            case (key_code)
                KEY_CAM:  next_mode = CAM;
                KEY_IR:   next_mode = IR;
                KEY_IDLE: next_mode = IDLE;
                default:  next_mode = mode;     // Unknown keys are ignored
            endcase
        end

        case (cam_state)
            PAUSE:   next_cam = (next_mode == CAM) ? SEARCH : PAUSE;
            SEARCH:  next_cam = (next_mode != CAM) ? PAUSE :
                                cam_status.target_seen ? FOLLOW : SEARCH;
            FOLLOW:  next_cam = (next_mode != CAM) ? PAUSE :
                                cam_status.target_seen ? FOLLOW : SEARCH;
            default: next_cam = PAUSE;
        endcase

        next_drive = STOP;
        if (next_cam == SEARCH) begin
            next_drive = RIGHT;                 // Spin in place to look for the target
        end else if (next_cam == FOLLOW) begin
            case (cam_status.direction)
                DIR_LEFT:  next_drive = LEFT;
                DIR_RIGHT: next_drive = RIGHT;
                DIR_AHEAD: begin
                    case (cam_status.speed)
                        2'd0:    next_drive = SLOW;
                        2'd1:    next_drive = MEDIUM;
                        2'd2:    next_drive = FAST;
                        default: next_drive = STOP;
                    endcase
                end
                default:   next_drive = STOP;
            endcase
        end
    end

    // ==========================================================
    // State registers
    // ==========================================================

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            mode         <= IDLE;
            cam_state    <= PAUSE;
            drive_action <= STOP;
            mode_change  <= 1'b0;
        end else begin
            mode         <= next_mode;
            cam_state    <= next_cam;
            drive_action <= next_drive;
            mode_change  <= (next_mode != mode) || (next_cam != cam_state);
        end
    end

    a_stop_outside_cam: assert property (@(posedge clk_50) disable iff (!rst_n)
        (mode != CAM) |-> (drive_action == STOP));

endmodule

//--- rtl/ir_nec_decoder.sv
`timescale 1ns/1ns

module ir_nec_decoder
    import rover_pkg::*;
(
    input  logic       clk_50,
    input  logic       rst_n,
    input  logic       ir_in,
    output logic       key_valid,
    output logic [7:0] key_code
);

    typedef enum logic [1:0] {
        IR_IDLE,
        IR_LEAD,
        IR_BITS
    } ir_state_e;

    ir_state_e            state;
    logic [IR_TICK_W-1:0] tick_cnt;
    logic                 tick;
    logic                 ir_meta;
    logic                 ir_sync;
    logic                 ir_prev;
    logic                 fall_edge;
    logic                 rise_edge;
    logic [IR_CNT_W-1:0]  len_cnt;
    logic [IR_CNT_W-1:0]  frame_cnt;
    logic [5:0]           bit_cnt;
    logic [31:0]          shift_reg;

    // ==========================================================
    // Time base and input sampling
    // ==========================================================

    assign tick = (tick_cnt == IR_TICK_W'(IR_TICK_DIV - 1));

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            ir_meta  <= 1'b1;                   // Receiver line idles high
            ir_sync  <= 1'b1;
            ir_prev  <= 1'b1;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            ir_meta  <= ir_in;
            ir_sync  <= ir_meta;
            ir_prev  <= ir_sync;
        end
    end

    assign fall_edge = ir_prev & ~ir_sync;      // A mark begins
    assign rise_edge = ~ir_prev & ir_sync;      // A mark ends

    // ==========================================================
    // Frame state machine
    // ==========================================================

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IR_IDLE;
            len_cnt   <= '0;
            frame_cnt <= '0;
            bit_cnt   <= '0;
            key_valid <= 1'b0;
            key_code  <= '0;
        end else begin
            key_valid <= 1'b0;
            if (fall_edge || rise_edge) begin
                len_cnt <= '0;                  // Each mark and space is timed alone
            end else if (tick && len_cnt != '1) begin
                len_cnt <= len_cnt + 1'b1;
            end
            if (state == IR_IDLE) begin
                frame_cnt <= '0;
            end else if (tick) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            case (state)
                IR_IDLE: begin
                    if (fall_edge) state <= IR_LEAD;
                end
                IR_LEAD: begin
                    // A falling edge here can only follow a long enough lead mark
                    if (rise_edge && len_cnt < IR_LEAD_MIN) begin
                        state <= IR_IDLE;
                    end else if (fall_edge) begin
                        state   <= IR_BITS;
                        bit_cnt <= '0;
                    end
                end
                IR_BITS: begin
                    if (fall_edge && bit_cnt != 6'(IR_FRAME_BITS)) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end else if (rise_edge && bit_cnt == 6'(IR_FRAME_BITS)) begin
                        state <= IR_IDLE;       // End of the stop mark
                        if (shift_reg[23:16] == ~shift_reg[31:24]) begin
                            key_valid <= 1'b1;
                            key_code  <= shift_reg[23:16];
                        end
                    end
                end
                default: state <= IR_IDLE;
            endcase
            if (state != IR_IDLE && frame_cnt > IR_TIMEOUT) begin
                state <= IR_IDLE;               // Overrides any step taken above
            end
        end
    end

    // LSB first, so the inverted command ends up in the top byte
    always_ff @(posedge clk_50) begin
        if (state == IR_BITS && fall_edge && bit_cnt != 6'(IR_FRAME_BITS)) begin
            shift_reg <= {(len_cnt >= IR_BIT_ONE), shift_reg[31:1]};
        end
    end

    a_key_pulse: assert property (@(posedge clk_50) disable iff (!rst_n)
        key_valid |=> !key_valid);

endmodule

//--- rtl/rover_pkg.sv
package rover_pkg;

    // ==========================================================
    // Modes, sub-states and opcodes
    // ==========================================================

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        CAM  = 2'b01,
        IR   = 2'b10
    } mode_e;

    typedef enum logic [1:0] {
        SEARCH = 2'b00,
        FOLLOW = 2'b01,
        PAUSE  = 2'b11
    } cam_state_e;

    typedef enum logic [2:0] {
        STOP   = 3'b000,
        LEFT   = 3'b001,
        RIGHT  = 3'b010,
        SLOW   = 3'b011,
        MEDIUM = 3'b100,
        FAST   = 3'b101
    } drive_e;

    typedef enum logic [2:0] {
        DIR_NONE  = 3'b000,
        DIR_LEFT  = 3'b001,
        DIR_RIGHT = 3'b010,
        DIR_AHEAD = 3'b011
    } cam_dir_e;

    // ==========================================================
    // Bundled signals
    // ==========================================================

    typedef struct packed {
        logic       target_seen;
        cam_dir_e   direction;
        logic [1:0] speed;           // 0 slow, 1 medium, 2 fast, 3 invalid
    } cam_status_t;

    typedef struct packed {
        logic [7:0] duty_left;       // All ones while the PWM level is high
        logic [7:0] duty_right;
        logic       fwd_left;
        logic       fwd_right;
    } motor_cmd_t;

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        logic [3:0] paddr;
        logic [7:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [7:0] prdata;
        logic       pready;
        logic       pslverr;
    } apb_rsp_t;

    // ==========================================================
    // Constants
    // ==========================================================

    localparam logic [7:0] KEY_CAM  = 8'h0f;
    localparam logic [7:0] KEY_IR   = 8'h13;
    localparam logic [7:0] KEY_IDLE = 8'h10;

    // IR timing is counted in units of IR_TICK_DIV clocks unless noted
    localparam int IR_TICK_DIV   = 25;      // Clocks per IR timing unit
    localparam int IR_TICK_W     = $clog2(IR_TICK_DIV);
    localparam int IR_CNT_W      = 8;
    localparam int IR_LEAD_MIN   = 12;      // Nominal lead mark is 16 units
    localparam int IR_BIT_ONE    = 2;       // Space of 1 unit is a 0, 3 units is a 1
    localparam int IR_TIMEOUT    = 180;
    localparam int IR_FRAME_BITS = 32;

    localparam int PWM_BITS = 8;

    localparam logic [3:0] REG_DUTY_SLOW = 4'd0;
    localparam logic [3:0] REG_DUTY_MED  = 4'd1;
    localparam logic [3:0] REG_DUTY_FAST = 4'd2;
    localparam logic [3:0] REG_DUTY_TURN = 4'd3;
    localparam logic [3:0] REG_STATUS    = 4'd4;

    localparam logic [7:0] DUTY_SLOW_RST = 8'd64;
    localparam logic [7:0] DUTY_MED_RST  = 8'd128;
    localparam logic [7:0] DUTY_FAST_RST = 8'd192;
    localparam logic [7:0] DUTY_TURN_RST = 8'd96;

endpackage
